// File: src/m2a_pkg.sv
package m2a_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned WORD_W     = 32;
    localparam int unsigned LINE_WORDS = 8;
    localparam int unsigned LINE_W     = LINE_WORDS * WORD_W;
    localparam int unsigned SIZE_W     = 6;
    localparam int unsigned CNT_W      = $clog2(LINE_WORDS);
    localparam int unsigned WORD_BYTES = 4;

    typedef logic [SIZE_W-1:0] size_code_t;
    typedef logic [CNT_W-1:0]  word_idx_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    ////////////////////
    // memory bus requests
    ////////////////////
    typedef struct packed {
        addr_t      addr;
        size_code_t size;
    } rd_req_t;

    typedef struct packed {
        addr_t      addr;
        size_code_t size;
        line_t      data;
    } wr_req_t;

    ////////////////////
    // axi channel payloads
    ////////////////////
    typedef struct packed {
        addr_t addr;
    } axi_addr_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } axi_w_t;

    // index of the final word for a size code
    function automatic word_idx_t beat_count(input size_code_t size);
        word_idx_t last;
        case (size)
            6'h00, 6'h01, 6'h03: last = 3'd0;
            6'h07:               last = 3'd1;
            6'h0f:               last = 3'd3;
            6'h1f:               last = 3'd7;
            // 64 byte code would not fit a line
            default:             last = 3'd0;
        endcase
        return last;
    endfunction

endpackage

// File: src/rd_ctrl.sv
`timescale 1ns/100ps

module rd_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               r_req_i,
    input  m2a_pkg::rd_req_t   r_req_data_i,
    output logic               r_rdy_o,
    output logic               ar_valid_o,
    output m2a_pkg::axi_addr_t ar_payload_o,
    input  logic               ar_ready_i,
    input  logic               r_valid_i,
    output logic               r_ready_o,
    output logic               beat_o,
    output m2a_pkg::word_idx_t beat_idx_o,
    output logic               beat_last_o
);

    m2a_pkg::rd_req_t   req_q;
    m2a_pkg::word_idx_t last_idx;
    m2a_pkg::word_idx_t ar_cnt_q;
    m2a_pkg::word_idx_t r_cnt_q;
    logic               ar_pend_q;
    logic               r_pend_q;
    logic               accept;
    logic               ar_fire;
    logic               r_fire;

    // idle once both channels have finished
    assign r_rdy_o  = !ar_pend_q && !r_pend_q;
    assign accept   = r_req_i && r_rdy_o;
    assign last_idx = m2a_pkg::beat_count(req_q.size);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= r_req_data_i;
        end
    end

    ////////////////////
    // ar issue
    ////////////////////
    assign ar_fire = ar_pend_q && ar_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ar_pend_q <= 1'b0;
            ar_cnt_q  <= '0;
        end else if (accept) begin
            ar_pend_q <= 1'b1;
            ar_cnt_q  <= '0;
        end else if (ar_fire) begin
            if (ar_cnt_q == last_idx) begin
                ar_pend_q <= 1'b0;
            end else begin
                ar_cnt_q <= ar_cnt_q + 1'b1;
            end
        end
    end

    assign ar_valid_o        = ar_pend_q;
    // one word per beat
    assign ar_payload_o.addr = req_q.addr + m2a_pkg::addr_t'(ar_cnt_q) * m2a_pkg::WORD_BYTES;

    ////////////////////
    // r beat count
    ////////////////////
    // beats may overlap the ar issue
    assign r_fire = r_pend_q && r_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend_q <= 1'b0;
            r_cnt_q  <= '0;
        end else if (accept) begin
            r_pend_q <= 1'b1;
            r_cnt_q  <= '0;
        end else if (r_fire) begin
            if (r_cnt_q == last_idx) begin
                r_pend_q <= 1'b0;
            end else begin
                r_cnt_q <= r_cnt_q + 1'b1;
            end
        end
    end

    assign r_ready_o = r_pend_q;

    // strobe and slot for the assembler
    assign beat_o      = r_fire;
    assign beat_idx_o  = r_cnt_q;
    assign beat_last_o = (r_cnt_q == last_idx);

endmodule

// File: src/rd_line_assembler.sv
`timescale 1ns/100ps

module rd_line_assembler (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               beat_i,
    input  m2a_pkg::word_idx_t beat_idx_i,
    input  logic               beat_last_i,
    input  m2a_pkg::word_t     r_data_i,
    output m2a_pkg::line_t     re_data_o,
    output logic               re_valid_o
);

    // line viewed as word slots with word 0 lowest
    m2a_pkg::word_t [m2a_pkg::LINE_WORDS-1:0] slots_q;
    logic                                     valid_q;

    ////////////////////
    // slot writes
    ////////////////////
    // untouched slots keep the previous line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slots_q <= '0;
        end else if (beat_i) begin
            slots_q[beat_idx_i] <= r_data_i;
        end
    end

    ////////////////////
    // completion
    ////////////////////
    // one cycle after the final word lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_i && beat_last_i;
        end
    end

    assign re_data_o  = slots_q;
    assign re_valid_o = valid_q;

endmodule

// File: src/wr_ctrl.sv
`timescale 1ns/100ps

module wr_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               iw_req_i,
    input  m2a_pkg::wr_req_t   iw_req_data_i,
    output logic               iw_rdy_o,
    output logic               aw_valid_o,
    output m2a_pkg::axi_addr_t aw_payload_o,
    input  logic               aw_ready_i,
    output logic               start_o,
    output m2a_pkg::line_t     line_o,
    output m2a_pkg::word_idx_t last_idx_o,
    input  logic               w_done_i
);

    m2a_pkg::wr_req_t   req_q;
    m2a_pkg::word_idx_t last_idx;
    m2a_pkg::word_idx_t aw_cnt_q;
    logic               aw_pend_q;
    logic               accept;
    logic               aw_fire;

    // idle needs the aw side and the w side both finished
    assign iw_rdy_o = !aw_pend_q && w_done_i;
    assign accept   = iw_req_i && iw_rdy_o;
    assign last_idx = m2a_pkg::beat_count(req_q.size);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= iw_req_data_i;
        end
    end

    ////////////////////
    // aw issue
    ////////////////////
    assign aw_fire = aw_pend_q && aw_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_pend_q <= 1'b0;
            aw_cnt_q  <= '0;
        end else if (accept) begin
            aw_pend_q <= 1'b1;
            aw_cnt_q  <= '0;
        end else if (aw_fire) begin
            // pend drops once the final address has moved
            if (aw_cnt_q == last_idx) begin
                aw_pend_q <= 1'b0;
            end else begin
                aw_cnt_q <= aw_cnt_q + 1'b1;
            end
        end
    end

    assign aw_valid_o        = aw_pend_q;
    assign aw_payload_o.addr = req_q.addr + m2a_pkg::addr_t'(aw_cnt_q) * m2a_pkg::WORD_BYTES;

    ////////////////////
    // slicer hand-off
    ////////////////////
    // start lines up with the request latch so w_valid rises with aw_valid
    assign start_o    = accept;
    assign line_o     = req_q.data;
    assign last_idx_o = last_idx;

endmodule

// File: src/wr_beat_slicer.sv
`timescale 1ns/100ps

module wr_beat_slicer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  m2a_pkg::line_t     line_i,
    input  m2a_pkg::word_idx_t last_idx_i,
    output logic               w_valid_o,
    output m2a_pkg::axi_w_t    w_payload_o,
    input  logic               w_ready_i,
    output logic               w_done_o
);

    m2a_pkg::word_t [m2a_pkg::LINE_WORDS-1:0] words;
    m2a_pkg::word_idx_t                       w_cnt_q;
    logic                                     w_valid_q;
    logic                                     w_done_q;
    logic                                     w_fire;
    logic                                     at_last;

    assign words   = line_i;
    assign w_fire  = w_valid_q && w_ready_i;
    assign at_last = (w_cnt_q == last_idx_i);

    ////////////////////
    // beat counter
    ////////////////////
    // idle counts as done so the write side starts ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_valid_q <= 1'b0;
            w_done_q  <= 1'b1;
            w_cnt_q   <= '0;
        end else if (start_i) begin
            w_valid_q <= 1'b1;
            w_done_q  <= 1'b0;
            w_cnt_q   <= '0;
        end else if (w_fire) begin
            if (at_last) begin
                w_valid_q <= 1'b0;
                w_done_q  <= 1'b1;
            end else begin
                w_cnt_q <= w_cnt_q + 1'b1;
            end
        end
    end

    ////////////////////
    // word select
    ////////////////////
    assign w_valid_o        = w_valid_q;
    assign w_payload_o.data = words[w_cnt_q];
    assign w_payload_o.last = at_last;
    assign w_done_o         = w_done_q;

endmodule

// File: src/mem2axi.sv
`timescale 1ns/100ps

module mem2axi (
    input  logic               clk,
    input  logic               rst_n,

    // memory read side
    input  logic               r_req,
    input  m2a_pkg::rd_req_t   r_req_data,
    output logic               r_rdy,
    output m2a_pkg::line_t     re_data,
    output logic               re_valid,

    // memory write side
    input  logic               iw_req,
    input  m2a_pkg::wr_req_t   iw_req_data,
    output logic               iw_rdy,

    // axi read
    output logic               ar_valid,
    output m2a_pkg::axi_addr_t ar_payload,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  m2a_pkg::axi_r_t    r_payload,
    output logic               r_ready,

    // axi write
    output logic               aw_valid,
    output m2a_pkg::axi_addr_t aw_payload,
    input  logic               aw_ready,
    output logic               w_valid,
    output m2a_pkg::axi_w_t    w_payload,
    input  logic               w_ready
);

    logic               rd_beat;
    m2a_pkg::word_idx_t rd_beat_idx;
    logic               rd_beat_last;

    logic               wr_start;
    m2a_pkg::line_t     wr_line;
    m2a_pkg::word_idx_t wr_last_idx;
    logic               wr_w_done;

    ////////////////////
    // read path
    ////////////////////
    rd_ctrl u_rd_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .r_req_i      (r_req),
        .r_req_data_i (r_req_data),
        .r_rdy_o      (r_rdy),
        .ar_valid_o   (ar_valid),
        .ar_payload_o (ar_payload),
        .ar_ready_i   (ar_ready),
        .r_valid_i    (r_valid),
        .r_ready_o    (r_ready),
        .beat_o       (rd_beat),
        .beat_idx_o   (rd_beat_idx),
        .beat_last_o  (rd_beat_last)
    );

    // every beat is single, so the r last bit carries nothing
    rd_line_assembler u_rd_line_assembler (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_i      (rd_beat),
        .beat_idx_i  (rd_beat_idx),
        .beat_last_i (rd_beat_last),
        .r_data_i    (r_payload.data),
        .re_data_o   (re_data),
        .re_valid_o  (re_valid)
    );

    ////////////////////
    // write path
    ////////////////////
    wr_ctrl u_wr_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .iw_req_i      (iw_req),
        .iw_req_data_i (iw_req_data),
        .iw_rdy_o      (iw_rdy),
        .aw_valid_o    (aw_valid),
        .aw_payload_o  (aw_payload),
        .aw_ready_i    (aw_ready),
        .start_o       (wr_start),
        .line_o        (wr_line),
        .last_idx_o    (wr_last_idx),
        .w_done_i      (wr_w_done)
    );

    wr_beat_slicer u_wr_beat_slicer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (wr_start),
        .line_i      (wr_line),
        .last_idx_i  (wr_last_idx),
        .w_valid_o   (w_valid),
        .w_payload_o (w_payload),
        .w_ready_i   (w_ready),
        .w_done_o    (wr_w_done)
    );

endmodule

// File: verification/axi_slave_model.sv
`timescale 1ns/100ps

module axi_slave_model (
    input  logic               clk,
    input  logic               rst_n,
    input  m2a_pkg::word_t     fill_key_i,
    input  logic               ar_valid_i,
    input  m2a_pkg::axi_addr_t ar_payload_i,
    output logic               ar_ready_o,
    output logic               r_valid_o,
    output m2a_pkg::axi_r_t    r_payload_o,
    input  logic               r_ready_i,
    input  logic               aw_valid_i,
    input  m2a_pkg::axi_addr_t aw_payload_i,
    output logic               aw_ready_o,
    input  logic               w_valid_i,
    input  m2a_pkg::axi_w_t    w_payload_i,
    output logic               w_ready_o
);

    localparam int MEM_WORDS = 64;

    m2a_pkg::word_t mem [MEM_WORDS];
    m2a_pkg::addr_t ar_q [$];
    m2a_pkg::addr_t aw_q [$];
    m2a_pkg::word_t w_q [$];
    m2a_pkg::addr_t waddr;
    m2a_pkg::addr_t raddr;
    logic           r_done;

    initial begin
        ar_ready_o  = 1'b0;
        aw_ready_o  = 1'b0;
        w_ready_o   = 1'b0;
        r_valid_o   = 1'b0;
        r_payload_o = '0;
        r_done      = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                ar_q.delete();
                aw_q.delete();
                w_q.delete();
                // pattern over the whole byte address keyed by the seed
                for (int i = 0; i < MEM_WORDS; i++) begin
                    mem[i] = (i * 4 * 32'h9e37_79b9) ^ fill_key_i;
                end
            end else begin
                if (ar_valid_i && ar_ready_o) ar_q.push_back(ar_payload_i.addr);
                if (aw_valid_i && aw_ready_o) aw_q.push_back(aw_payload_i.addr);
                if (w_valid_i && w_ready_o) w_q.push_back(w_payload_i.data);
                // pair addresses and words in issue order
                while (aw_q.size() > 0 && w_q.size() > 0) begin
                    waddr = aw_q.pop_front();
                    mem[waddr[7:2]] = w_q.pop_front();
                end
            end
            r_done = r_valid_o && r_ready_i;
            #1;
            if (!rst_n) begin
                ar_ready_o = 1'b0;
                aw_ready_o = 1'b0;
                w_ready_o  = 1'b0;
                r_valid_o  = 1'b0;
            end else begin
                // stall each ready about one cycle in four
                ar_ready_o = ($urandom_range(3) != 0);
                aw_ready_o = ($urandom_range(3) != 0);
                w_ready_o  = ($urandom_range(3) != 0);
                if (r_done) r_valid_o = 1'b0;
                if (!r_valid_o && ar_q.size() > 0 && $urandom_range(3) != 0) begin
                    raddr            = ar_q.pop_front();
                    r_payload_o.data = mem[raddr[7:2]];
                    r_payload_o.last = 1'b1;
                    r_valid_o        = 1'b1;
                end
            end
        end
    end

endmodule

// File: verification/mem2axi_chk.sv
`timescale 1ns/100ps

module mem2axi_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               ar_valid_i,
    input logic               ar_ready_i,
    input m2a_pkg::axi_addr_t ar_payload_i,
    input logic               aw_valid_i,
    input logic               aw_ready_i,
    input m2a_pkg::axi_addr_t aw_payload_i,
    input logic               w_valid_i,
    input logic               w_ready_i,
    input m2a_pkg::axi_w_t    w_payload_i,
    input logic               re_valid_i
);

    int unsigned fail_cnt = 0;

    ////////////////////
    // valid and payload hold while stalled
    ////////////////////
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_payload_i))
        else begin
            $error("ar channel changed while stalled");
            fail_cnt++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_payload_i))
        else begin
            $error("aw channel changed while stalled");
            fail_cnt++;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_payload_i))
        else begin
            $error("w channel changed while stalled");
            fail_cnt++;
        end

    // line strobe is a single pulse
    a_re_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        re_valid_i |=> !re_valid_i)
        else begin
            $error("re_valid held longer than one cycle");
            fail_cnt++;
        end

endmodule

bind mem2axi mem2axi_chk u_mem2axi_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_i   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_payload_i (ar_payload),
    .aw_valid_i   (aw_valid),
    .aw_ready_i   (aw_ready),
    .aw_payload_i (aw_payload),
    .w_valid_i    (w_valid),
    .w_ready_i    (w_ready),
    .w_payload_i  (w_payload),
    .re_valid_i   (re_valid)
);

// File: verification/mem2axi_tb.sv
`timescale 1ns/100ps

module mem2axi_tb;

    localparam int unsigned SEED        = 32'h3f84_6bdd;
    localparam int          MEM_WORDS   = 64;
    localparam int          NUM_ITER    = 40;
    // at most a write and a read per iteration plus reset
    localparam int          CYCLE_LIMIT = 2 * NUM_ITER * 200 + 20;

    logic clk;
    logic rst_n;
    logic r_req;
    logic iw_req;
    logic r_rdy;
    logic iw_rdy;
    logic re_valid;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;
    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;

    m2a_pkg::rd_req_t   r_req_data;
    m2a_pkg::wr_req_t   iw_req_data;
    m2a_pkg::line_t     re_data;
    m2a_pkg::axi_addr_t ar_payload;
    m2a_pkg::axi_addr_t aw_payload;
    m2a_pkg::axi_r_t    r_payload;
    m2a_pkg::axi_w_t    w_payload;
    m2a_pkg::word_t     fill_key;

    // reference model state
    m2a_pkg::word_t  model_mem [MEM_WORDS];
    m2a_pkg::line_t  prev_line;
    m2a_pkg::addr_t  ar_seen [$];
    m2a_pkg::addr_t  aw_seen [$];
    m2a_pkg::axi_w_t w_seen [$];
    int unsigned     errors;
    int              cycles;

    mem2axi u_mem2axi (
        .clk         (clk),
        .rst_n       (rst_n),
        .r_req       (r_req),
        .r_req_data  (r_req_data),
        .r_rdy       (r_rdy),
        .re_data     (re_data),
        .re_valid    (re_valid),
        .iw_req      (iw_req),
        .iw_req_data (iw_req_data),
        .iw_rdy      (iw_rdy),
        .ar_valid    (ar_valid),
        .ar_payload  (ar_payload),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .r_payload   (r_payload),
        .r_ready     (r_ready),
        .aw_valid    (aw_valid),
        .aw_payload  (aw_payload),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w_payload   (w_payload),
        .w_ready     (w_ready)
    );

    axi_slave_model u_axi_slave_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_key_i   (fill_key),
        .ar_valid_i   (ar_valid),
        .ar_payload_i (ar_payload),
        .ar_ready_o   (ar_ready),
        .r_valid_o    (r_valid),
        .r_payload_o  (r_payload),
        .r_ready_i    (r_ready),
        .aw_valid_i   (aw_valid),
        .aw_payload_i (aw_payload),
        .aw_ready_o   (aw_ready),
        .w_valid_i    (w_valid),
        .w_payload_i  (w_payload),
        .w_ready_o    (w_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
        end
    end

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, a request never completed", cycles);
        $display("Test failed");
        $finish;
    end

    // record every accepted address and write beat
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (ar_valid && ar_ready) ar_seen.push_back(ar_payload.addr);
                if (aw_valid && aw_ready) aw_seen.push_back(aw_payload.addr);
                if (w_valid && w_ready) w_seen.push_back(w_payload);
            end
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_line(input m2a_pkg::line_t got, input m2a_pkg::line_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input m2a_pkg::addr_t got, input m2a_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input m2a_pkg::word_t got, input m2a_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(input m2a_pkg::axi_w_t got, input m2a_pkg::axi_w_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h/%b expected %h/%b", $time, what,
                     got.data, got.last, exp.data, exp.last);
        end
    endtask

    ////////////////////
    // reference rules
    ////////////////////
    // last word index per size code
    // unlisted codes mean one word
    function automatic int last_word_index(input m2a_pkg::size_code_t size);
        case (size)
            6'h07:   return 1;
            6'h0f:   return 3;
            6'h1f:   return 7;
            default: return 0;
        endcase
    endfunction

    function automatic m2a_pkg::size_code_t pick_size();
        m2a_pkg::size_code_t size;
        case ($urandom_range(7))
            0:       size = 6'h00;
            1:       size = 6'h01;
            2:       size = 6'h03;
            3:       size = 6'h07;
            4:       size = 6'h0f;
            5:       size = 6'h1f;
            6:       size = 6'h3f;
            default: size = 6'($urandom_range(63));
        endcase
        return size;
    endfunction

    ////////////////////
    // request tasks
    ////////////////////
    task automatic do_write(input m2a_pkg::addr_t base, input m2a_pkg::size_code_t size,
                            input m2a_pkg::line_t line);
        int              last;
        m2a_pkg::addr_t  exp_addr;
        m2a_pkg::axi_w_t exp_beat;
        last = last_word_index(size);
        #1;
        iw_req           = 1'b1;
        iw_req_data.addr = base;
        iw_req_data.size = size;
        iw_req_data.data = line;
        @(posedge clk);
        while (!iw_rdy) @(posedge clk);
        #1 iw_req = 1'b0;
        @(posedge clk);
        while (!iw_rdy) @(posedge clk);
        check_word(m2a_pkg::word_t'(aw_seen.size()), m2a_pkg::word_t'(last + 1), "aw count");
        check_word(m2a_pkg::word_t'(w_seen.size()), m2a_pkg::word_t'(last + 1), "w count");
        for (int k = 0; k <= last; k++) begin
            exp_addr      = base + m2a_pkg::addr_t'(k * 4);
            exp_beat.data = line[k*m2a_pkg::WORD_W +: m2a_pkg::WORD_W];
            exp_beat.last = (k == last);
            if (k < aw_seen.size()) check_addr(aw_seen[k], exp_addr, "aw address");
            if (k < w_seen.size()) check_beat(w_seen[k], exp_beat, "w beat");
            model_mem[exp_addr[7:2]] = exp_beat.data;
        end
        aw_seen.delete();
        w_seen.delete();
    endtask

    task automatic do_read(input m2a_pkg::addr_t base, input m2a_pkg::size_code_t size);
        int             last;
        m2a_pkg::addr_t exp_addr;
        m2a_pkg::line_t exp_line;
        last     = last_word_index(size);
        exp_line = prev_line;
        for (int k = 0; k <= last; k++) begin
            exp_addr = base + m2a_pkg::addr_t'(k * 4);
            exp_line[k*m2a_pkg::WORD_W +: m2a_pkg::WORD_W] = model_mem[exp_addr[7:2]];
        end
        #1;
        r_req           = 1'b1;
        r_req_data.addr = base;
        r_req_data.size = size;
        @(posedge clk);
        while (!r_rdy) @(posedge clk);
        #1 r_req = 1'b0;
        @(posedge clk);
        while (!re_valid) @(posedge clk);
        check_line(re_data, exp_line, "read line");
        check_word(m2a_pkg::word_t'(ar_seen.size()), m2a_pkg::word_t'(last + 1), "ar count");
        for (int k = 0; k <= last && k < ar_seen.size(); k++) begin
            check_addr(ar_seen[k], base + m2a_pkg::addr_t'(k * 4), "ar address");
        end
        ar_seen.delete();
        prev_line = exp_line;
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        m2a_pkg::addr_t      base;
        m2a_pkg::size_code_t size;
        m2a_pkg::line_t      line;
        int unsigned         assert_fails;
        void'($urandom(SEED));
        errors      = 0;
        rst_n       = 1'b0;
        r_req       = 1'b0;
        r_req_data  = '0;
        iw_req      = 1'b0;
        iw_req_data = '0;
        prev_line   = '0;
        fill_key    = $urandom;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = (i * 4 * 32'h9e37_79b9) ^ fill_key;
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        if (!r_rdy || !iw_rdy || ar_valid || aw_valid || w_valid || r_ready || re_valid) begin
            errors++;
            $display("outputs were not idle after reset at %0t", $time);
        end

        for (int n = 0; n < NUM_ITER; n++) begin
            base = m2a_pkg::addr_t'($urandom_range(MEM_WORDS - m2a_pkg::LINE_WORDS)) * 4;
            size = pick_size();
            // half the reads come straight after a write to the same words
            if ($urandom_range(1) == 1) begin
                for (int k = 0; k < m2a_pkg::LINE_WORDS; k++) begin
                    line[k*m2a_pkg::WORD_W +: m2a_pkg::WORD_W] = $urandom;
                end
                do_write(base, size, line);
            end
            do_read(base, size);
        end

        assert_fails = u_mem2axi.u_mem2axi_chk.fail_cnt;
        $display("run done: %0d mismatches, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: mem2axi.f
src/m2a_pkg.sv
src/rd_ctrl.sv
src/rd_line_assembler.sv
src/wr_ctrl.sv
src/wr_beat_slicer.sv
src/mem2axi.sv
verification/axi_slave_model.sv
verification/mem2axi_chk.sv
verification/mem2axi_tb.sv

// File: run_sim.sh
#!/bin/sh
# build mem2axi_tb with Verilator, run it, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module mem2axi_tb -f mem2axi.f -o mem2axi_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem2axi_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
